//--- common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ##########################################################################
// Core constants
// ##########################################################################

// First fetch address after reset.
`define RESET_PC 32'h1c00_0000

// General register file depth.
`define REG_COUNT 32

`define LINK_REG 5'd1 // Link target of bl.

`endif

//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Three-register format.
    typedef struct packed {
        logic [5:0] op6;
        logic [3:0] op4;
        logic [1:0] op2;
        logic [4:0] op5;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } inst_3r_t;

    typedef struct packed {
        logic [5:0]  op6;
        logic [3:0]  op4;
        logic [11:0] i12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri12_t;

    typedef struct packed {
        logic [6:0]  op7;
        logic [19:0] i20; // Upper immediate of lu12i.w.
        logic [4:0]  rd;
    } inst_1ri20_t;

    typedef struct packed {
        logic [5:0]  op6;
        logic [15:0] i16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri16_t;

    // Long branch, offset split around the opcode.
    typedef struct packed {
        logic [5:0]  op6;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } inst_i26_t;

    typedef union packed {
        inst_3r_t    r3;
        inst_2ri12_t ri12;
        inst_1ri20_t ri20;
        inst_2ri16_t ri16;
        inst_i26_t   i26;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR,  ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_FETCH     = 3'd0,
        ST_DECODE    = 3'd1,
        ST_EXECUTE   = 3'd2,
        ST_MEMORY    = 3'd3,
        ST_WRITEBACK = 3'd4
    } state_e;

endpackage

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_e alu_op,
    input  logic [31:0]      alu_src1,
    input  logic [31:0]      alu_src2,
    output logic [31:0]      alu_result
);
    logic [4:0]  shamt;
    logic        lt_signed;
    logic        lt_unsigned;
    logic [31:0] sra_result;

    assign shamt = alu_src2[4:0]; // Word shifts use five bits.

    assign lt_signed   = $signed(alu_src1) < $signed(alu_src2);
    assign lt_unsigned = alu_src1 < alu_src2;
    assign sra_result  = $signed(alu_src1) >>> shamt;

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD:  alu_result = alu_src1 + alu_src2;
            cpu_pkg::ALU_SUB:  alu_result = alu_src1 - alu_src2;
            cpu_pkg::ALU_SLT:  alu_result = {31'd0, lt_signed};
            cpu_pkg::ALU_SLTU: alu_result = {31'd0, lt_unsigned};
            cpu_pkg::ALU_AND:  alu_result = alu_src1 & alu_src2;
            cpu_pkg::ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            cpu_pkg::ALU_OR:   alu_result = alu_src1 | alu_src2;
            cpu_pkg::ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            cpu_pkg::ALU_SLL:  alu_result = alu_src1 << shamt;
            cpu_pkg::ALU_SRL:  alu_result = alu_src1 >> shamt;
            cpu_pkg::ALU_SRA:  alu_result = sra_result;
            cpu_pkg::ALU_LUI:  alu_result = alu_src2; // Already shifted by the decoder.
            default:           alu_result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);
    logic [31:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Register zero reads as zero.
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

//--- design/pc_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module pc_counter (
    input  logic        clk,
    input  logic        reset,
    input  logic        load,
    input  logic        take_target,
    input  logic [31:0] target,
    output logic [31:0] pc
);
    logic [31:0] seq_pc;

    assign seq_pc = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (load) begin
            pc <= take_target ? target : seq_pc;
        end
    end

    // Targets from jirl come from a register, so check alignment here.
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
    else $error("pc_counter: unaligned pc %h", pc);

endmodule

`default_nettype wire

//--- decode/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module inst_decoder (
    input  cpu_pkg::inst_u   inst,
    input  logic [31:0]      pc,
    input  logic [31:0]      rj_value,
    input  logic [31:0]      rkd_value,
    output cpu_pkg::alu_op_e alu_op,
    output logic             src1_is_pc,
    output logic             src2_is_imm,
    output logic [31:0]      imm,
    output logic             src_reg_is_rd,
    output logic [4:0]       dest,
    output logic             writes_reg,
    output logic             is_mem,
    output logic             is_store,
    output logic             is_load,
    output logic             is_branch_only,
    output logic             take_target,
    output logic [31:0]      target
);
    logic        grp_3r;
    logic        grp_shift;
    logic        inst_add_w;
    logic        inst_sub_w;
    logic        inst_slt;
    logic        inst_sltu;
    logic        inst_nor;
    logic        inst_and;
    logic        inst_or;
    logic        inst_xor;
    logic        inst_slli_w;
    logic        inst_srli_w;
    logic        inst_srai_w;
    logic        inst_addi_w;
    logic        inst_lu12i_w;
    logic        inst_ld_w;
    logic        inst_st_w;
    logic        inst_jirl;
    logic        inst_b;
    logic        inst_bl;
    logic        inst_beq;
    logic        inst_bne;
    logic        known;
    logic        gr_we;
    logic        rj_eq_rd;
    logic [31:0] offs16;
    logic [31:0] offs26;

    // ######################################################################
    // Opcode match
    // ######################################################################

    assign grp_3r    = inst.r3.op6 == 6'h00 && inst.r3.op4 == 4'h0 && inst.r3.op2 == 2'h1;
    assign grp_shift = inst.r3.op6 == 6'h00 && inst.r3.op4 == 4'h1 && inst.r3.op2 == 2'h0;

    assign inst_add_w   = grp_3r && inst.r3.op5 == 5'h00;
    assign inst_sub_w   = grp_3r && inst.r3.op5 == 5'h02;
    assign inst_slt     = grp_3r && inst.r3.op5 == 5'h04;
    assign inst_sltu    = grp_3r && inst.r3.op5 == 5'h05;
    assign inst_nor     = grp_3r && inst.r3.op5 == 5'h08;
    assign inst_and     = grp_3r && inst.r3.op5 == 5'h09;
    assign inst_or      = grp_3r && inst.r3.op5 == 5'h0a;
    assign inst_xor     = grp_3r && inst.r3.op5 == 5'h0b;
    assign inst_slli_w  = grp_shift && inst.r3.op5 == 5'h01;
    assign inst_srli_w  = grp_shift && inst.r3.op5 == 5'h09;
    assign inst_srai_w  = grp_shift && inst.r3.op5 == 5'h11;
    assign inst_addi_w  = inst.ri12.op6 == 6'h00 && inst.ri12.op4 == 4'ha;
    assign inst_ld_w    = inst.ri12.op6 == 6'h0a && inst.ri12.op4 == 4'h2;
    assign inst_st_w    = inst.ri12.op6 == 6'h0a && inst.ri12.op4 == 4'h6;
    assign inst_lu12i_w = inst.ri20.op7 == 7'h0a;
    assign inst_jirl    = inst.ri16.op6 == 6'h13;
    assign inst_b       = inst.i26.op6 == 6'h14;
    assign inst_bl      = inst.i26.op6 == 6'h15;
    assign inst_beq     = inst.ri16.op6 == 6'h16;
    assign inst_bne     = inst.ri16.op6 == 6'h17;

    assign known = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_slli_w | inst_srli_w | inst_srai_w
                 | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w | inst_jirl
                 | inst_b | inst_bl | inst_beq | inst_bne;

    always_comb begin
        case (1'b1)
            inst_sub_w:   alu_op = cpu_pkg::ALU_SUB;
            inst_slt:     alu_op = cpu_pkg::ALU_SLT;
            inst_sltu:    alu_op = cpu_pkg::ALU_SLTU;
            inst_and:     alu_op = cpu_pkg::ALU_AND;
            inst_nor:     alu_op = cpu_pkg::ALU_NOR;
            inst_or:      alu_op = cpu_pkg::ALU_OR;
            inst_xor:     alu_op = cpu_pkg::ALU_XOR;
            inst_slli_w:  alu_op = cpu_pkg::ALU_SLL;
            inst_srli_w:  alu_op = cpu_pkg::ALU_SRL;
            inst_srai_w:  alu_op = cpu_pkg::ALU_SRA;
            inst_lu12i_w: alu_op = cpu_pkg::ALU_LUI;
            default:      alu_op = cpu_pkg::ALU_ADD; // Sums, addresses, links.
        endcase
    end

    // ######################################################################
    // Operands and immediates
    // ######################################################################

    assign src1_is_pc    = inst_jirl | inst_bl;
    assign src2_is_imm   = grp_shift | inst_addi_w | inst_ld_w | inst_st_w
                         | inst_lu12i_w | inst_jirl | inst_bl;
    assign src_reg_is_rd = inst_beq | inst_bne | inst_st_w;

    assign imm = (inst_jirl || inst_bl) ? 32'd4 :                  // Link value.
                 inst_lu12i_w           ? {inst.ri20.i20, 12'd0} :
                 grp_shift              ? {27'd0, inst.r3.rk} :
                 {{20{inst.ri12.i12[11]}}, inst.ri12.i12};

    assign dest       = inst_bl ? `LINK_REG : inst.r3.rd;
    assign gr_we      = known & ~inst_st_w & ~inst_beq & ~inst_bne & ~inst_b;
    assign writes_reg = gr_we && dest != 5'd0;

    assign is_load        = inst_ld_w;
    assign is_store       = inst_st_w;
    assign is_mem         = inst_ld_w | inst_st_w;
    assign is_branch_only = inst_b | inst_beq | inst_bne;

    // Branch targets.
    assign offs16 = {{14{inst.ri16.i16[15]}}, inst.ri16.i16, 2'b00};
    assign offs26 = {{4{inst.i26.offs_hi[9]}}, inst.i26.offs_hi, inst.i26.offs_lo, 2'b00};

    assign rj_eq_rd    = rj_value == rkd_value;
    assign take_target = inst_b | inst_bl | inst_jirl
                       | (inst_beq & rj_eq_rd) | (inst_bne & ~rj_eq_rd);
    assign target      = inst_jirl          ? rj_value + offs16 :
                         (inst_b || inst_bl) ? pc + offs26 :
                         pc + offs16;

endmodule

`default_nettype wire

//--- control/cpu_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_fsm (
    input  logic            clk,
    input  logic            reset,
    input  logic            is_branch_only,
    input  logic            is_mem,
    input  logic            is_store,
    input  logic            writes_reg,
    output cpu_pkg::state_e state,
    output logic            ir_load,
    output logic            pc_load,
    output logic            alu_latch,
    output logic            mem_latch,
    output logic            data_we,
    output logic            rf_we
);
    cpu_pkg::state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::ST_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = cpu_pkg::ST_FETCH;
        ir_load    = 1'b0;
        pc_load    = 1'b0;
        alu_latch  = 1'b0;
        mem_latch  = 1'b0;
        data_we    = 1'b0;
        rf_we      = 1'b0;
        case (state)
            cpu_pkg::ST_FETCH: begin
                ir_load    = 1'b1;
                state_next = cpu_pkg::ST_DECODE;
            end
            cpu_pkg::ST_DECODE: begin
                pc_load = is_branch_only; // Branches finish here.
                if (!is_branch_only) begin
                    state_next = cpu_pkg::ST_EXECUTE;
                end
            end
            cpu_pkg::ST_EXECUTE: begin
                alu_latch = 1'b1;
                if (is_mem) begin
                    state_next = cpu_pkg::ST_MEMORY;
                end else begin
                    state_next = cpu_pkg::ST_WRITEBACK;
                end
            end
            cpu_pkg::ST_MEMORY: begin
                data_we   = is_store;
                pc_load   = is_store;
                mem_latch = !is_store;
                if (!is_store) begin
                    state_next = cpu_pkg::ST_WRITEBACK;
                end
            end
            cpu_pkg::ST_WRITEBACK: begin
                rf_we   = writes_reg;
                pc_load = 1'b1;
            end
            default: begin
                state_next = cpu_pkg::ST_FETCH;
            end
        endcase
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && state inside {cpu_pkg::ST_FETCH, cpu_pkg::ST_DECODE,
            cpu_pkg::ST_EXECUTE, cpu_pkg::ST_MEMORY, cpu_pkg::ST_WRITEBACK})
    else $error("cpu_fsm: illegal state %0d", state);

    // Store strobe lasts one memory cycle, then fetch resumes.
    a_data_we_rule: assert property (@(posedge clk) disable iff (reset)
        data_we |-> (state == cpu_pkg::ST_MEMORY) ##1
            (state == cpu_pkg::ST_FETCH && !data_we))
    else $error("cpu_fsm: data_we outside a single memory cycle");

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    cpu_pkg::state_e  state;
    cpu_pkg::inst_u   ir;
    cpu_pkg::alu_op_e alu_op;

    logic        ir_load;
    logic        pc_load;
    logic        alu_latch;
    logic        mem_latch;
    logic        data_we;
    logic        rf_we;
    logic [31:0] pc;
    logic [31:0] alu_result_q;
    logic [31:0] load_data_q;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic [31:0] imm;
    logic        src_reg_is_rd;
    logic [4:0]  dest;
    logic        writes_reg;
    logic        is_mem;
    logic        is_store;
    logic        is_load;
    logic        is_branch_only;
    logic        take_target;
    logic [31:0] target;
    logic [4:0]  rf_raddr2;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [31:0] wb_data;

    // ######################################################################
    // Datapath registers
    // ######################################################################

    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir <= inst_sram_rdata;
        end
        if (alu_latch) begin
            alu_result_q <= alu_result;
        end
        if (mem_latch) begin
            load_data_q <= data_sram_rdata; // ld.w only.
        end
    end

    assign rf_raddr2 = src_reg_is_rd ? ir.r3.rd : ir.r3.rk;
    assign alu_src1  = src1_is_pc ? pc : rj_value;
    assign alu_src2  = src2_is_imm ? imm : rkd_value;
    assign wb_data   = is_load ? load_data_q : alu_result_q;

    cpu_fsm i_cpu_fsm (
        .clk            (clk),
        .reset          (reset),
        .is_branch_only (is_branch_only),
        .is_mem         (is_mem),
        .is_store       (is_store),
        .writes_reg     (writes_reg),
        .state          (state),
        .ir_load        (ir_load),
        .pc_load        (pc_load),
        .alu_latch      (alu_latch),
        .mem_latch      (mem_latch),
        .data_we        (data_we),
        .rf_we          (rf_we)
    );

    pc_counter i_pc_counter (
        .clk         (clk),
        .reset       (reset),
        .load        (pc_load),
        .take_target (take_target),
        .target      (target),
        .pc          (pc)
    );

    inst_decoder i_inst_decoder (
        .inst           (ir),
        .pc             (pc),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .alu_op         (alu_op),
        .src1_is_pc     (src1_is_pc),
        .src2_is_imm    (src2_is_imm),
        .imm            (imm),
        .src_reg_is_rd  (src_reg_is_rd),
        .dest           (dest),
        .writes_reg     (writes_reg),
        .is_mem         (is_mem),
        .is_store       (is_store),
        .is_load        (is_load),
        .is_branch_only (is_branch_only),
        .take_target    (take_target),
        .target         (target)
    );

    regfile i_regfile (
        .clk    (clk),
        .raddr1 (ir.r3.rj),
        .rdata1 (rj_value),
        .raddr2 (rf_raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (wb_data)
    );

    alu i_alu (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    // ######################################################################
    // Memory and trace ports
    // ######################################################################

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = 32'd0;

    assign data_sram_we    = data_we;
    assign data_sram_addr  = alu_result_q;
    assign data_sram_wdata = rkd_value;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = wb_data;

    // Register writes come only in writeback and never target r0.
    a_rf_write_rule: assert property (@(posedge clk) disable iff (reset)
        rf_we |-> (state == cpu_pkg::ST_WRITEBACK) && (dest != 5'd0))
    else $error("cpu_top: register write to r%0d in state %0d", dest, state);

endmodule

`default_nettype wire

//--- test/tb_sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_model (
    input  logic        clk,
    input  logic        inst_we,
    input  logic [31:0] inst_addr,
    input  logic [31:0] inst_wdata,
    output logic [31:0] inst_rdata,
    input  logic        data_we,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic [31:0] data_rdata
);
    localparam int WORDS = 256;

    logic [31:0] imem [WORDS];
    logic [31:0] dmem [WORDS];

    // Hash of the word address.
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e37_79b9;
        return h ^ {h[15:0], h[31:16]} ^ 32'h6a09_e667;
    endfunction

    task automatic fill_background();
        int i;
        for (i = 0; i < WORDS; i++) begin
            imem[i] <= fill_word(32'(i) << 2);
            dmem[i] <= ~fill_word(32'(i) << 2);
        end
    endtask

    task automatic load_inst(input int index, input logic [31:0] word);
        imem[index] <= word;
    endtask

    // Reads answer in the same cycle.
    assign inst_rdata = imem[inst_addr[9:2]];
    assign data_rdata = dmem[data_addr[9:2]];

    always @(posedge clk) begin
        if (inst_we) begin
            imem[inst_addr[9:2]] <= inst_wdata;
        end
        if (data_we) begin
            dmem[data_addr[9:2]] <= data_wdata;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module tb_cpu_top;

    localparam int          TRACE_MAX   = 32;
    localparam int          TIMEOUT     = 400;
    localparam logic [31:0] STORE_ADDR  = `RESET_PC + 32'h100;
    localparam logic [31:0] STORE_DATA  = 32'hffff_fffe;
    localparam int          STORE_CYCLE = 67;

    // Opcode fields as laid out in the ISA manual.
    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_SLT     = 17'h00024;
    localparam logic [16:0] OP_SLTU    = 17'h00025;
    localparam logic [16:0] OP_NOR     = 17'h00028;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [16:0] OP_XOR     = 17'h0002b;
    localparam logic [16:0] OP_SLLI_W  = 17'h00081;
    localparam logic [16:0] OP_SRLI_W  = 17'h00089;
    localparam logic [16:0] OP_SRAI_W  = 17'h00091;
    localparam logic [9:0]  OP_ADDI_W  = 10'h00a;
    localparam logic [9:0]  OP_LD_W    = 10'h0a2;
    localparam logic [9:0]  OP_ST_W    = 10'h0a6;
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;
    localparam logic [5:0]  OP_JIRL    = 6'h13;
    localparam logic [5:0]  OP_B       = 6'h14;
    localparam logic [5:0]  OP_BL      = 6'h15;
    localparam logic [5:0]  OP_BEQ     = 6'h16;
    localparam logic [5:0]  OP_BNE     = 6'h17;

    logic        clk;
    logic        reset;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic [31:0] exp_pc    [TRACE_MAX];
    logic [4:0]  exp_num   [TRACE_MAX];
    logic [31:0] exp_data  [TRACE_MAX];
    int          exp_cycle [TRACE_MAX];
    int          n_entries;
    int          trace_idx;
    int          cycle;
    int          store_count;
    int          waited;
    logic        wb_fire;

    cpu_top i_cpu_top (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_sram_model i_sram_model (
        .clk        (clk),
        .inst_we    (inst_sram_we),
        .inst_addr  (inst_sram_addr),
        .inst_wdata (inst_sram_wdata),
        .inst_rdata (inst_sram_rdata),
        .data_we    (data_sram_we),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata)
    );

    // ########################################################################
    // Instruction encoding
    // ########################################################################

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
            input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [9:0] op, input logic [11:0] si12,
            input logic [4:0] rj, input logic [4:0] rd);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_1ri20(input logic [6:0] op, input logic [19:0] si20,
            input logic [4:0] rd);
        return {op, si20, rd};
    endfunction

    // Offsets count words.
    function automatic logic [31:0] enc_2ri16(input logic [5:0] op, input logic [15:0] offs,
            input logic [4:0] rj, input logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic load_program();
        int i;
        // A filler that runs shows up as a stray write to r20.
        for (i = 0; i < 32; i++) begin
            i_sram_model.load_inst(i, enc_2ri12(OP_ADDI_W, 12'h7ff, 5'd0, 5'd20));
        end
        i_sram_model.load_inst(0,  enc_2ri12(OP_ADDI_W, 12'hffb, 5'd0, 5'd4)); // r4 = -5.
        i_sram_model.load_inst(1,  enc_2ri12(OP_ADDI_W, 12'd3, 5'd0, 5'd5));
        i_sram_model.load_inst(2,  enc_3r(OP_ADD_W, 5'd5, 5'd4, 5'd6));
        i_sram_model.load_inst(3,  enc_3r(OP_SUB_W, 5'd4, 5'd5, 5'd7));
        i_sram_model.load_inst(4,  enc_3r(OP_SLT, 5'd5, 5'd4, 5'd8));
        i_sram_model.load_inst(5,  enc_3r(OP_SLTU, 5'd5, 5'd4, 5'd9));
        i_sram_model.load_inst(6,  enc_3r(OP_NOR, 5'd7, 5'd5, 5'd10));
        i_sram_model.load_inst(7,  enc_3r(OP_AND, 5'd7, 5'd4, 5'd11));
        i_sram_model.load_inst(8,  enc_3r(OP_OR, 5'd7, 5'd5, 5'd12));
        i_sram_model.load_inst(9,  enc_3r(OP_XOR, 5'd5, 5'd4, 5'd13));
        i_sram_model.load_inst(10, enc_3r(OP_SLLI_W, 5'd4, 5'd5, 5'd14));
        i_sram_model.load_inst(11, enc_3r(OP_SRLI_W, 5'd1, 5'd4, 5'd15));
        i_sram_model.load_inst(12, enc_3r(OP_SRAI_W, 5'd1, 5'd4, 5'd16));
        i_sram_model.load_inst(13, enc_1ri20(OP_LU12I_W, 20'h1c000, 5'd17));
        i_sram_model.load_inst(14, enc_2ri12(OP_ADDI_W, 12'd7, 5'd5, 5'd0)); // Lost in r0.
        i_sram_model.load_inst(15, enc_3r(OP_ADD_W, 5'd5, 5'd0, 5'd18));
        i_sram_model.load_inst(16, enc_2ri12(OP_ST_W, 12'h100, 5'd17, 5'd6));
        i_sram_model.load_inst(17, enc_2ri12(OP_LD_W, 12'h100, 5'd17, 5'd19));
        i_sram_model.load_inst(18, enc_2ri16(OP_BEQ, 16'd2, 5'd5, 5'd18)); // Taken.
        i_sram_model.load_inst(20, enc_2ri16(OP_BEQ, 16'd2, 5'd5, 5'd4));  // Falls through.
        i_sram_model.load_inst(21, enc_2ri16(OP_BNE, 16'd2, 5'd5, 5'd4));
        i_sram_model.load_inst(23, enc_i26(OP_B, 26'd2));
        i_sram_model.load_inst(25, enc_i26(OP_BL, 26'd3));
        i_sram_model.load_inst(28, enc_2ri16(OP_JIRL, 16'd4, 5'd1, 5'd21));
        i_sram_model.load_inst(30, enc_2ri12(OP_ADDI_W, 12'd1, 5'd21, 5'd22));
        i_sram_model.load_inst(31, enc_i26(OP_B, 26'd0)); // Halt loop.
    endtask

    task automatic add_trace(input logic [31:0] pc_off, input logic [4:0] num,
            input logic [31:0] data, input int at_cycle);
        exp_pc[n_entries]    = `RESET_PC + pc_off;
        exp_num[n_entries]   = num;
        exp_data[n_entries]  = data;
        exp_cycle[n_entries] = at_cycle;
        n_entries++;
    endtask

    // Cycle 0 is the first fetch after reset.
    task automatic load_trace();
        add_trace(32'h00, 5'd4,  32'hffff_fffb, 3);
        add_trace(32'h04, 5'd5,  32'h0000_0003, 7);
        add_trace(32'h08, 5'd6,  32'hffff_fffe, 11);
        add_trace(32'h0c, 5'd7,  32'h0000_0008, 15);
        add_trace(32'h10, 5'd8,  32'h0000_0001, 19);
        add_trace(32'h14, 5'd9,  32'h0000_0000, 23);
        add_trace(32'h18, 5'd10, 32'hffff_fff4, 27);
        add_trace(32'h1c, 5'd11, 32'h0000_0008, 31);
        add_trace(32'h20, 5'd12, 32'h0000_000b, 35);
        add_trace(32'h24, 5'd13, 32'hffff_fff8, 39);
        add_trace(32'h28, 5'd14, 32'h0000_0030, 43);
        add_trace(32'h2c, 5'd15, 32'h7fff_fffd, 47);
        add_trace(32'h30, 5'd16, 32'hffff_fffd, 51);
        add_trace(32'h34, 5'd17, 32'h1c00_0000, 55);
        add_trace(32'h3c, 5'd18, 32'h0000_0003, 63);
        add_trace(32'h44, 5'd19, 32'hffff_fffe, 72); // Load takes five cycles.
        add_trace(32'h64, 5'd1,  32'h1c00_0068, 84);
        add_trace(32'h70, 5'd21, 32'h1c00_0074, 88);
        add_trace(32'h78, 5'd22, 32'h1c00_0075, 92);
    endtask

    // ########################################################################
    // Clock, counters and checks
    // ########################################################################

    always #4 clk = ~clk;

    assign wb_fire = debug_wb_rf_we != 4'h0;

    always @(posedge clk) begin
        if (reset) begin
            cycle       <= 0;
            trace_idx   <= 0;
            store_count <= 0;
        end else begin
            cycle <= cycle + 1;
            if (wb_fire) begin
                trace_idx <= trace_idx + 1;
            end
            if (data_sram_we) begin
                store_count <= store_count + 1;
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        (cycle < exp_cycle[0]) |-> (!data_sram_we && debug_wb_rf_we == 4'h0))
    else begin
        $display("[FAIL] data_sram_we = %h debug_wb_rf_we = %h before first writeback",
            $sampled(data_sram_we), $sampled(debug_wb_rf_we));
        fail_run();
    end

    // Instruction memory is read only.
    a_no_inst_write: assert property (@(posedge clk) disable iff (reset)
        !inst_sram_we && !$isunknown(inst_sram_wdata))
    else begin
        $display("[FAIL] inst_sram_we = %h inst_sram_wdata = %h, expected 0 and known data",
            $sampled(inst_sram_we), $sampled(inst_sram_wdata));
        fail_run();
    end

    a_no_extra_write: assert property (@(posedge clk) disable iff (reset)
        wb_fire |-> trace_idx < n_entries)
    else begin
        $display("Register write past the end of the expected trace");
        fail_run();
    end

    a_wb_we: assert property (@(posedge clk) disable iff (reset)
        wb_fire |-> debug_wb_rf_we == 4'hf)
    else begin
        $display("[FAIL] debug_wb_rf_we = %h, expected f", $sampled(debug_wb_rf_we));
        fail_run();
    end

    a_wb_pc: assert property (@(posedge clk) disable iff (reset)
        (wb_fire && trace_idx < n_entries) |-> debug_wb_pc == exp_pc[trace_idx])
    else begin
        $display("[FAIL] debug_wb_pc = %h, expected %h",
            $sampled(debug_wb_pc), exp_pc[$sampled(trace_idx)]);
        fail_run();
    end

    a_wb_wnum: assert property (@(posedge clk) disable iff (reset)
        (wb_fire && trace_idx < n_entries) |-> debug_wb_rf_wnum == exp_num[trace_idx])
    else begin
        $display("[FAIL] debug_wb_rf_wnum = %h, expected %h",
            $sampled(debug_wb_rf_wnum), exp_num[$sampled(trace_idx)]);
        fail_run();
    end

    a_wb_wdata: assert property (@(posedge clk) disable iff (reset)
        (wb_fire && trace_idx < n_entries) |-> debug_wb_rf_wdata == exp_data[trace_idx])
    else begin
        $display("[FAIL] debug_wb_rf_wdata = %h, expected %h",
            $sampled(debug_wb_rf_wdata), exp_data[$sampled(trace_idx)]);
        fail_run();
    end

    a_wb_cycle: assert property (@(posedge clk) disable iff (reset)
        (wb_fire && trace_idx < n_entries) |-> cycle == exp_cycle[trace_idx])
    else begin
        $display("[FAIL] writeback cycle = %h, expected %h",
            $sampled(cycle), exp_cycle[$sampled(trace_idx)]);
        fail_run();
    end

    a_store: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> (data_sram_addr == STORE_ADDR && data_sram_wdata == STORE_DATA
            && cycle == STORE_CYCLE))
    else begin
        $display("[FAIL] data_sram_addr = %h data_sram_wdata = %h cycle = %h, expected %h %h %h",
            $sampled(data_sram_addr), $sampled(data_sram_wdata), $sampled(cycle),
            STORE_ADDR, STORE_DATA, STORE_CYCLE);
        fail_run();
    end

    a_store_one_cycle: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |=> !data_sram_we)
    else begin
        $display("Store strobe held for more than one cycle");
        fail_run();
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        n_entries = 0;
        i_sram_model.fill_background();
        load_program();
        load_trace();
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        assert (inst_sram_addr == `RESET_PC)
        else begin
            $display("[FAIL] inst_sram_addr = %h, expected %h", inst_sram_addr, `RESET_PC);
            fail_run();
        end
        waited = 0;
        while (trace_idx < n_entries && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        repeat (10) @(posedge clk); // Halt loop, no more writes.
        if (trace_idx < n_entries) begin
            $display("Timed out after %0d cycles with %0d of %0d writebacks seen",
                waited, trace_idx, n_entries);
            fail_run();
        end else if (store_count != 1) begin
            $display("Store strobe seen %0d times instead of once", store_count);
            fail_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/cpu_pkg.sv
design/alu.sv
design/regfile.sv
design/pc_counter.sv
decode/inst_decoder.sv
control/cpu_fsm.sv
design/cpu_top.sv
test/tb_sram_model.sv
test/tb_cpu_top.sv

//--- Bender.yml
package:
  name: la32_multicycle_cpu

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - design/alu.sv
      - design/regfile.sv
      - design/pc_counter.sv
      - decode/inst_decoder.sv
      - control/cpu_fsm.sv
      - design/cpu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_sram_model.sv
      - test/tb_cpu_top.sv
